// ==== files.f ====
pcap_replay_pkg.sv
packet_mem_if.sv
packet_store.sv
packet_capture.sv
replay_reader.sv
replay_ctrl.sv
stream_fifo.sv
pcap_replay_top.sv
tb_clock_gen.sv
tb_pcap_replay.sv

// ==== Bender.yml ====
package:
  name: pcap_replay

sources:
  - pcap_replay_pkg.sv
  - packet_mem_if.sv
  - packet_store.sv
  - packet_capture.sv
  - replay_reader.sv
  - replay_ctrl.sv
  - stream_fifo.sv
  - pcap_replay_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_pcap_replay.sv

// ==== tb_pcap_replay.sv ====
// Testbench for the capture-and-replay engine with a capture model and random back-pressure
`default_nettype none

module tb_pcap_replay;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NQ = pcap_replay_pkg::NUM_QUEUES;
  localparam int DEPTH = pcap_replay_pkg::REGION_DEPTH;
  // Four replays of 256 words under back-pressure plus capture time
  localparam int CYCLE_LIMIT = 20000;

  logic                                            clk;
  logic                                            rst;
  logic                                            replay_start;
  logic                                            capture_clear;
  logic                                            replay_busy;
  logic [pcap_replay_pkg::DATA_W-1:0]              s_axis_tdata;
  logic [pcap_replay_pkg::TUSER_W-1:0]             s_axis_tuser;
  logic                                            s_axis_tvalid;
  logic                                            s_axis_tready;
  logic                                            s_axis_tlast;
  logic [NQ-1:0][pcap_replay_pkg::DATA_W-1:0]      m_axis_tdata;
  logic [NQ-1:0]                                   m_axis_tvalid;
  logic [NQ-1:0]                                   m_axis_tready;
  logic [NQ-1:0]                                   m_axis_tlast;

  // Expected words per queue from the capture rules
  logic [pcap_replay_pkg::MEM_W-1:0] exp_mem [NQ][DEPTH];
  int     exp_count [NQ];
  int     out_idx [NQ];
  logic   last_tlast [NQ];
  int     model_qid;
  logic   model_in_pkt;
  logic   model_drop;
  int     seed = 32'hdbf6_a7a6;
  int     ready_seed = 32'hdbf6_a7a6;
  int     cycles = 0;
  string  test_name;

  tb_clock_gen clock_gen_i (
    .clk (clk),
    .rst (rst)
  );

  pcap_replay_top dut_i (
    .axi_aclk      (clk),
    .rst           (rst),
    .replay_start  (replay_start),
    .capture_clear (capture_clear),
    .replay_busy   (replay_busy),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tuser  (s_axis_tuser),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tlast  (s_axis_tlast),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast)
  );

  task automatic fail_value(input string what, input logic [32:0] expected,
                            input logic [32:0] actual);
    $display("Fail %s %s expected %h actual %h", test_name, what, expected, actual);
    $display("Checks failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic fail_plain(input string what);
    $display("Error in %s: %s", test_name, what);
    $display("Checks failed");
    $fatal(1, "Stopped at first error");
  endtask

  // One accepted beat through the capture rules
  task automatic model_beat(input logic [7:0] dst, input logic [31:0] data, input logic last);
    logic stored_last;
    if (!model_in_pkt) begin
      model_qid = -1;
      for (int i = 0; i < NQ; i++) begin
        if (dst[i] && model_qid < 0) begin
          model_qid = i;
        end
      end
      model_drop = (model_qid < 0);
    end
    if (!model_drop) begin
      if (exp_count[model_qid] == DEPTH) begin
        model_drop = 1'b1;
      end else begin
        // Final free slot closes the packet
        stored_last = last || (exp_count[model_qid] == DEPTH - 1);
        exp_mem[model_qid][exp_count[model_qid]] = {stored_last, data};
        exp_count[model_qid]++;
        model_drop = (exp_count[model_qid] == DEPTH);
      end
    end
    model_in_pkt = !last;
  endtask

  task automatic send_packet(input logic [7:0] dst, input int len);
    logic [31:0] data;
    for (int b = 0; b < len; b++) begin
      data = $random(seed);
      s_axis_tvalid = 1'b1;
      s_axis_tdata = data;
      s_axis_tuser = 32'(dst) << pcap_replay_pkg::DST_PORT_POS;
      s_axis_tlast = (b == len - 1);
      do @(posedge clk); while (!s_axis_tready);
      model_beat(dst, data, s_axis_tlast);
      #2;
    end
    s_axis_tvalid = 1'b0;
    s_axis_tlast = 1'b0;
  endtask

  task automatic send_random_packets(input int count);
    logic [7:0] dst;
    int len;
    for (int p = 0; p < count; p++) begin
      dst = $random(seed);
      len = 1 + ($random(seed) & 7);
      send_packet(dst, len);
    end
  endtask

  task automatic run_replay(input string name);
    test_name = name;
    for (int q = 0; q < NQ; q++) begin
      out_idx[q] = 0;
    end
    replay_start = 1'b1;
    @(posedge clk);
    #2;
    replay_start = 1'b0;
    assert (replay_busy) else fail_plain("replay_busy did not rise after replay_start");
    do @(posedge clk); while (replay_busy);
    // Buffers can still hold words once busy falls
    do @(posedge clk); while (m_axis_tvalid != '0);
    for (int q = 0; q < NQ; q++) begin
      assert (out_idx[q] == exp_count[q])
        else fail_value($sformatf("queue %0d beat count", q), exp_count[q], out_idx[q]);
    end
    #2;
  endtask

  // Scoreboard on every output queue
  always @(posedge clk) begin
    if (!rst) begin
      for (int q = 0; q < NQ; q++) begin
        if (m_axis_tvalid[q]) begin
          assert (out_idx[q] < exp_count[q])
            else fail_plain($sformatf("queue %0d shows a beat beyond its expected list", q));
          if (m_axis_tready[q]) begin
            assert ({m_axis_tlast[q], m_axis_tdata[q]} == exp_mem[q][out_idx[q]])
              else fail_value($sformatf("queue %0d beat %0d", q, out_idx[q]),
                              exp_mem[q][out_idx[q]], {m_axis_tlast[q], m_axis_tdata[q]});
            last_tlast[q] = m_axis_tlast[q];
            out_idx[q]++;
          end
        end
      end
    end
  end

  a_ready_low_busy: assert property (
    @(posedge clk) disable iff (rst) replay_busy |-> !s_axis_tready
  ) else fail_plain("s_axis_tready high while replay_busy");

  for (genvar q = 0; q < NQ; q++) begin : g_hold
    a_hold_beat: assert property (
      @(posedge clk) disable iff (rst)
      m_axis_tvalid[q] && !m_axis_tready[q] |=>
        m_axis_tvalid[q] && $stable(m_axis_tdata[q]) && $stable(m_axis_tlast[q])
    ) else fail_plain($sformatf("queue %0d changed its beat under back-pressure", q));
  end

  always @(posedge clk) begin
    #2;
    for (int q = 0; q < NQ; q++) begin
      m_axis_tready[q] = (($random(ready_seed) & 3) != 0);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the run did not finish", cycles);
      $display("Checks failed");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    replay_start = 1'b0;
    capture_clear = 1'b0;
    s_axis_tvalid = 1'b0;
    s_axis_tdata = '0;
    s_axis_tuser = '0;
    s_axis_tlast = 1'b0;
    m_axis_tready = '0;
    model_qid = 0;
    model_in_pkt = 1'b0;
    model_drop = 1'b0;
    for (int q = 0; q < NQ; q++) begin
      exp_count[q] = 0;
      out_idx[q] = 0;
      last_tlast[q] = 1'b0;
    end
    test_name = "reset";
    @(negedge rst);
    @(posedge clk);
    #2;
    assert (!replay_busy && m_axis_tvalid == '0 && s_axis_tready)
      else fail_plain("outputs not idle after reset");

    test_name = "capture";
    // No destination bit, so this one goes nowhere
    send_packet(8'hf0, 3);
    send_random_packets(16);
    run_replay("replay_first");
    run_replay("replay_repeat");

    test_name = "clear";
    capture_clear = 1'b1;
    @(posedge clk);
    #2;
    capture_clear = 1'b0;
    for (int q = 0; q < NQ; q++) begin
      exp_count[q] = 0;
    end
    run_replay("replay_empty");

    test_name = "overflow_capture";
    send_packet(8'h04, 70);
    send_packet(8'h01, 5);
    send_packet(8'h0a, 4);
    run_replay("replay_overflow");
    assert (out_idx[2] == DEPTH) else fail_value("overflow length", DEPTH, out_idx[2]);
    assert (last_tlast[2]) else fail_plain("final word of the full region lacks tlast");

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// Testbench clock and reset source with a 20 ns period and an 8-cycle reset
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 8;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== pcap_replay_top.sv ====
// Packet capture-and-replay engine top with one ingress stream and per-queue egress streams
`default_nettype none

module pcap_replay_top (
  input  logic                                   axi_aclk,
  input  logic                                   rst,
  input  logic                                   replay_start,
  input  logic                                   capture_clear,
  output logic                                   replay_busy,

  input  logic [pcap_replay_pkg::DATA_W-1:0]     s_axis_tdata,
  input  logic [pcap_replay_pkg::TUSER_W-1:0]    s_axis_tuser,
  input  logic                                   s_axis_tvalid,
  output logic                                   s_axis_tready,
  input  logic                                   s_axis_tlast,

  output logic [pcap_replay_pkg::NUM_QUEUES-1:0][pcap_replay_pkg::DATA_W-1:0] m_axis_tdata,
  output logic [pcap_replay_pkg::NUM_QUEUES-1:0] m_axis_tvalid,
  input  logic [pcap_replay_pkg::NUM_QUEUES-1:0] m_axis_tready,
  output logic [pcap_replay_pkg::NUM_QUEUES-1:0] m_axis_tlast
);

  logic                                   capture_en;
  logic                                   clear;
  logic                                   start;
  logic                                   in_packet;
  logic                                   in_flight;
  logic                                   grant_valid;
  logic [pcap_replay_pkg::QID_W-1:0]      grant_qid;
  logic [pcap_replay_pkg::NUM_QUEUES-1:0][pcap_replay_pkg::REGION_W:0] tails;
  logic [pcap_replay_pkg::NUM_QUEUES-1:0] pending;
  logic [pcap_replay_pkg::NUM_QUEUES-1:0] room;
  logic [pcap_replay_pkg::NUM_QUEUES-1:0] buf_wr_en;
  logic [pcap_replay_pkg::MEM_W-1:0]      buf_wr_data;

  packet_mem_if mem_bus ();

  packet_capture capture_i (
    .axi_aclk      (axi_aclk),
    .rst           (rst),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tuser  (s_axis_tuser),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tready (s_axis_tready),
    .capture_en    (capture_en),
    .clear         (clear),
    .tails         (tails),
    .in_packet     (in_packet),
    .mem           (mem_bus.capture)
  );

  packet_store store_i (
    .axi_aclk (axi_aclk),
    .mem      (mem_bus.store)
  );

  replay_reader reader_i (
    .axi_aclk    (axi_aclk),
    .rst         (rst),
    .start       (start),
    .grant_valid (grant_valid),
    .grant_qid   (grant_qid),
    .tails       (tails),
    .pending     (pending),
    .in_flight   (in_flight),
    .mem         (mem_bus.replay),
    .buf_wr_en   (buf_wr_en),
    .buf_wr_data (buf_wr_data)
  );

  replay_ctrl ctrl_i (
    .axi_aclk      (axi_aclk),
    .rst           (rst),
    .replay_start  (replay_start),
    .capture_clear (capture_clear),
    .in_packet     (in_packet),
    .pending       (pending),
    .room          (room),
    .in_flight     (in_flight),
    .capture_en    (capture_en),
    .clear         (clear),
    .start         (start),
    .grant_valid   (grant_valid),
    .grant_qid     (grant_qid),
    .replay_busy   (replay_busy)
  );

  // One egress buffer per queue
  for (genvar q = 0; q < pcap_replay_pkg::NUM_QUEUES; q++) begin : g_queue
    stream_fifo out_fifo_i (
      .axi_aclk      (axi_aclk),
      .rst           (rst),
      .wr_en         (buf_wr_en[q]),
      .wr_data       (buf_wr_data),
      .room          (room[q]),
      .m_axis_tdata  (m_axis_tdata[q]),
      .m_axis_tlast  (m_axis_tlast[q]),
      .m_axis_tvalid (m_axis_tvalid[q]),
      .m_axis_tready (m_axis_tready[q])
    );
  end

endmodule

`default_nettype wire

// ==== stream_fifo.sv ====
// Output buffer for one queue, presenting its head word as an AXI-Stream master
`default_nettype none

module stream_fifo (
  input  logic                               axi_aclk,
  input  logic                               rst,
  input  logic                               wr_en,
  input  logic [pcap_replay_pkg::MEM_W-1:0]  wr_data,
  output logic                               room,
  output logic [pcap_replay_pkg::DATA_W-1:0] m_axis_tdata,
  output logic                               m_axis_tlast,
  output logic                               m_axis_tvalid,
  input  logic                               m_axis_tready
);

  logic [pcap_replay_pkg::MEM_W-1:0]                slots [pcap_replay_pkg::OUT_DEPTH];
  logic [$clog2(pcap_replay_pkg::OUT_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(pcap_replay_pkg::OUT_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(pcap_replay_pkg::OUT_DEPTH+1)-1:0] count;
  logic                                            pop;

  assign pop = m_axis_tvalid && m_axis_tready;
  assign m_axis_tvalid = (count != '0);
  assign {m_axis_tlast, m_axis_tdata} = slots[rd_ptr];
  // Spare slots cover reads still in flight
  assign room = count < (pcap_replay_pkg::OUT_DEPTH - pcap_replay_pkg::OUT_MARGIN);

  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (wr_en) begin
      slots[wr_ptr] <= wr_data;
    end
  end

  a_no_overflow: assert property (
    @(posedge axi_aclk) disable iff (rst)
    wr_en |-> (count != pcap_replay_pkg::OUT_DEPTH)
  );

endmodule

`default_nettype wire

// ==== replay_ctrl.sv ====
// Replay controller sequencing capture, round-robin read grants and drain
`default_nettype none

module replay_ctrl (
  input  logic                                   axi_aclk,
  input  logic                                   rst,
  input  logic                                   replay_start,
  input  logic                                   capture_clear,
  input  logic                                   in_packet,
  input  logic [pcap_replay_pkg::NUM_QUEUES-1:0] pending,
  input  logic [pcap_replay_pkg::NUM_QUEUES-1:0] room,
  input  logic                                   in_flight,
  output logic                                   capture_en,
  output logic                                   clear,
  output logic                                   start,
  output logic                                   grant_valid,
  output logic [pcap_replay_pkg::QID_W-1:0]      grant_qid,
  output logic                                   replay_busy
);

  logic [1:0]                             state;
  logic [pcap_replay_pkg::QID_W-1:0]      last_qid;
  logic [pcap_replay_pkg::QID_W-1:0]      cand;
  logic [pcap_replay_pkg::NUM_QUEUES-1:0] eligible;

  // Start only between packets
  assign start = (state == pcap_replay_pkg::ST_CAPTURE) && replay_start && !in_packet;
  assign clear = (state == pcap_replay_pkg::ST_CAPTURE) && capture_clear;
  assign capture_en = (state == pcap_replay_pkg::ST_CAPTURE) && !start;
  assign replay_busy = (state != pcap_replay_pkg::ST_CAPTURE);
  assign eligible = pending & room;

  // Search starts just after the last granted queue
  always_comb begin
    grant_valid = 1'b0;
    grant_qid = last_qid;
    cand = last_qid;
    if (state == pcap_replay_pkg::ST_REPLAY) begin
      for (int i = pcap_replay_pkg::NUM_QUEUES; i >= 1; i--) begin
        cand = last_qid + i[pcap_replay_pkg::QID_W-1:0];
        if (eligible[cand]) begin
          grant_valid = 1'b1;
          grant_qid = cand;
        end
      end
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      state    <= pcap_replay_pkg::ST_CAPTURE;
      last_qid <= '0;
    end else begin
      if (grant_valid) begin
        last_qid <= grant_qid;
      end
      case (state)
        pcap_replay_pkg::ST_CAPTURE: begin
          if (start) begin
            state <= pcap_replay_pkg::ST_REPLAY;
          end
        end
        pcap_replay_pkg::ST_REPLAY: begin
          if (pending == '0) begin
            state <= pcap_replay_pkg::ST_DRAIN;
          end
        end
        // Wait out reads already issued
        pcap_replay_pkg::ST_DRAIN: begin
          if (!in_flight) begin
            state <= pcap_replay_pkg::ST_CAPTURE;
          end
        end
        default: begin
          state <= pcap_replay_pkg::ST_CAPTURE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== replay_reader.sv ====
// Replay reader walking each queue region and routing read words to the output buffers
`default_nettype none

module replay_reader (
  input  logic                                    axi_aclk,
  input  logic                                    rst,
  input  logic                                    start,
  input  logic                                    grant_valid,
  input  logic [pcap_replay_pkg::QID_W-1:0]       grant_qid,
  input  logic [pcap_replay_pkg::NUM_QUEUES-1:0][pcap_replay_pkg::REGION_W:0] tails,
  output logic [pcap_replay_pkg::NUM_QUEUES-1:0]  pending,
  output logic                                    in_flight,
  packet_mem_if.replay                            mem,
  output logic [pcap_replay_pkg::NUM_QUEUES-1:0]  buf_wr_en,
  output logic [pcap_replay_pkg::MEM_W-1:0]       buf_wr_data
);

  logic [pcap_replay_pkg::NUM_QUEUES-1:0][pcap_replay_pkg::REGION_W:0] rd_ptrs;
  logic [pcap_replay_pkg::QID_W-1:0] issue_qid;
  logic [pcap_replay_pkg::QID_W-1:0] return_qid;

  always_comb begin
    for (int q = 0; q < pcap_replay_pkg::NUM_QUEUES; q++) begin
      pending[q] = rd_ptrs[q] < tails[q];
    end
  end

  assign in_flight = mem.rd_en || mem.rd_valid;

  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      rd_ptrs   <= '0;
      mem.rd_en <= 1'b0;
    end else begin
      mem.rd_en <= grant_valid;
      // Tails are kept, so every replay restarts at offset 0
      if (start) begin
        rd_ptrs <= '0;
      end else if (grant_valid) begin
        rd_ptrs[grant_qid] <= rd_ptrs[grant_qid] + 1'b1;
      end
    end
  end

  // Queue id follows its read through the memory latency
  always_ff @(posedge axi_aclk) begin
    mem.rd_addr <= {grant_qid, rd_ptrs[grant_qid][pcap_replay_pkg::REGION_W-1:0]};
    issue_qid   <= grant_qid;
    return_qid  <= issue_qid;
  end

  always_comb begin
    buf_wr_en = '0;
    buf_wr_en[return_qid] = mem.rd_valid;
  end

  assign buf_wr_data = mem.rd_data;

  a_grant_pending: assert property (
    @(posedge axi_aclk) disable iff (rst)
    grant_valid |-> pending[grant_qid]
  );

endmodule

`default_nettype wire

// ==== packet_capture.sv ====
// Packet capture steering each ingress packet into its queue region of the store
`default_nettype none

module packet_capture (
  input  logic                                    axi_aclk,
  input  logic                                    rst,
  input  logic [pcap_replay_pkg::DATA_W-1:0]      s_axis_tdata,
  input  logic [pcap_replay_pkg::TUSER_W-1:0]     s_axis_tuser,
  input  logic                                    s_axis_tvalid,
  input  logic                                    s_axis_tlast,
  output logic                                    s_axis_tready,
  input  logic                                    capture_en,
  input  logic                                    clear,
  output logic [pcap_replay_pkg::NUM_QUEUES-1:0][pcap_replay_pkg::REGION_W:0] tails,
  output logic                                    in_packet,
  packet_mem_if.capture                           mem
);

  logic [pcap_replay_pkg::NUM_QUEUES-1:0] dst_ports;
  logic [pcap_replay_pkg::QID_W-1:0]      first_qid;
  logic [pcap_replay_pkg::QID_W-1:0]      held_qid;
  logic [pcap_replay_pkg::QID_W-1:0]      qid;
  logic                                   drop_rest;
  logic                                   accept;
  logic                                   discard;
  logic                                   store;
  logic                                   last_slot;

  assign s_axis_tready = capture_en;
  assign accept = s_axis_tvalid && capture_en;
  assign dst_ports = s_axis_tuser[pcap_replay_pkg::DST_PORT_POS +: pcap_replay_pkg::NUM_QUEUES];

  // Lowest set destination bit picks the queue
  always_comb begin
    first_qid = '0;
    for (int i = pcap_replay_pkg::NUM_QUEUES - 1; i >= 0; i--) begin
      if (dst_ports[i]) begin
        first_qid = i[pcap_replay_pkg::QID_W-1:0];
      end
    end
  end

  assign qid = in_packet ? held_qid : first_qid;
  assign discard = in_packet ? drop_rest : (dst_ports == '0);
  assign store = accept && !discard && (tails[qid] != pcap_replay_pkg::REGION_DEPTH);
  assign last_slot = (tails[qid] == pcap_replay_pkg::REGION_DEPTH - 1);

  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      in_packet <= 1'b0;
      drop_rest <= 1'b0;
      tails     <= '0;
      mem.wr_en <= 1'b0;
    end else begin
      mem.wr_en <= store;
      if (accept) begin
        in_packet <= !s_axis_tlast;
        // Region full, rest of this packet goes nowhere
        drop_rest <= !store || last_slot;
      end
      if (clear) begin
        tails <= '0;
      end else if (store) begin
        tails[qid] <= tails[qid] + 1'b1;
      end
    end
  end

  // Beat lands in memory on the following edge
  always_ff @(posedge axi_aclk) begin
    if (accept && !in_packet) begin
      held_qid <= first_qid;
    end
    mem.wr_addr <= {qid, tails[qid][pcap_replay_pkg::REGION_W-1:0]};
    mem.wr_data <= {s_axis_tlast || last_slot, s_axis_tdata};
  end

  for (genvar q = 0; q < pcap_replay_pkg::NUM_QUEUES; q++) begin : g_tail_chk
    a_tail_bound: assert property (
      @(posedge axi_aclk) disable iff (rst)
      tails[q] <= pcap_replay_pkg::REGION_DEPTH
    );
  end

endmodule

`default_nettype wire

// ==== packet_store.sv ====
// Packet store holding every captured word, one write port and a registered read port
`default_nettype none

module packet_store (
  input logic         axi_aclk,
  packet_mem_if.store mem
);

  logic [pcap_replay_pkg::MEM_W-1:0] words [2**pcap_replay_pkg::MEM_ADDR_W];

  always_ff @(posedge axi_aclk) begin
    if (mem.wr_en) begin
      words[mem.wr_addr] <= mem.wr_data;
    end
  end

  // Read data and its strobe come back together
  always_ff @(posedge axi_aclk) begin
    if (mem.rd_en) begin
      mem.rd_data <= words[mem.rd_addr];
    end
    mem.rd_valid <= mem.rd_en;
  end

  a_valid_after_read: assert property (
    @(posedge axi_aclk) mem.rd_valid |-> $past(mem.rd_en)
  );

endmodule

`default_nettype wire

// ==== packet_mem_if.sv ====
// Packet memory bus with one write port and one read port
`default_nettype none

interface packet_mem_if;

  logic                                 wr_en;
  logic [pcap_replay_pkg::MEM_ADDR_W-1:0] wr_addr;
  logic [pcap_replay_pkg::MEM_W-1:0]      wr_data;

  logic                                 rd_en;
  logic [pcap_replay_pkg::MEM_ADDR_W-1:0] rd_addr;
  // Valid one cycle after rd_en
  logic [pcap_replay_pkg::MEM_W-1:0]      rd_data;
  logic                                 rd_valid;

  modport capture (
    output wr_en, wr_addr, wr_data
  );

  modport replay (
    output rd_en, rd_addr,
    input  rd_data, rd_valid
  );

  modport store (
    input  wr_en, wr_addr, wr_data, rd_en, rd_addr,
    output rd_data, rd_valid
  );

endinterface

`default_nettype wire

// ==== pcap_replay_pkg.sv ====
// Capture-and-replay engine constants shared by every block
`default_nettype none

package pcap_replay_pkg;

  // Stream widths
  localparam int DATA_W = 32;
  localparam int TUSER_W = 32;
  // One-hot destination field, one bit per queue
  localparam int DST_PORT_POS = 24;

  localparam int NUM_QUEUES = 4;
  localparam int QID_W = 2;

  // Each queue owns a fixed region of the word memory
  localparam int REGION_DEPTH = 64;
  localparam int REGION_W = 6;
  localparam int MEM_ADDR_W = 8;
  // Data plus last flag on top
  localparam int MEM_W = 33;

  localparam int OUT_DEPTH = 8;
  localparam int OUT_MARGIN = 2;

  // Controller states
  localparam logic [1:0] ST_CAPTURE = 2'd0;
  localparam logic [1:0] ST_REPLAY = 2'd1;
  localparam logic [1:0] ST_DRAIN = 2'd2;

endpackage

`default_nettype wire
